// ==== Makefile ====
TOP = a2_card_tb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f a2_card_top.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f a2_card_top.f -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^Done: no errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== a2_card_top.f ====
+incdir+verilog
verilog/a2_bus_pkg.sv
verilog/a2_av_pkg.sv
verilog/card_resp_if.sv
verilog/a2_clock_recovery.sv
verilog/a2_card_arbiter.sv
verilog/a2_audio_mixer.sv
verilog/a2_video_post.sv
verilog/a2_front_panel.sv
verilog/a2_card_top.sv
verification/a2_card_asserts.sv
verification/a2_card_tb.sv

// ==== verification/a2_card_asserts.sv ====
// Concurrent checks on the card top level for interrupts, phi1 edges and bus drive
`timescale 1ns/1ps
`default_nettype none

module a2_card_asserts (
    input wire clk_logic_w,
    input wire rst_i,
    input wire ssc_irq_n_i,
    input wire ssp_irq_n_i,
    input wire mb_irq_n_i,
    input wire phi1_posedge_i,
    input wire phi1_negedge_i,
    input wire ssc_rd_i,
    input wire ssp_rd_i,
    input wire mb_rd_i,
    input wire disk_rd_i,
    input wire data_out_en_i,
    input wire irq_n_i
);

    logic any_rd_w;

    assign any_rd_w = ssc_rd_i | ssp_rd_i | mb_rd_i | disk_rd_i;

    // Interrupt out only follows a card interrupt of the previous cycle
    irq_source_a: assert property (@(posedge clk_logic_w) disable iff (rst_i)
        !irq_n_i |-> !$past(ssc_irq_n_i & ssp_irq_n_i & mb_irq_n_i))
        else $error("irq_n_o went low with no card interrupt pending");

    // Each phi1 edge pulse lasts one cycle and stands apart from the next
    phi1_edges_a: assert property (@(posedge clk_logic_w) disable iff (rst_i)
        (phi1_posedge_i || phi1_negedge_i) |=> !(phi1_posedge_i || phi1_negedge_i))
        else $error("phi1 edge pulses overlap in consecutive cycles");

    // Bus drive released once no card reads
    data_release_a: assert property (@(posedge clk_logic_w) disable iff (rst_i)
        !any_rd_w |=> !data_out_en_i)
        else $error("data_out_en_o still set after all card reads ended");

endmodule

bind a2_card_top a2_card_asserts asserts0 (
    .clk_logic_w    (clk_logic_w),
    .rst_i          (rst_i),
    .ssc_irq_n_i    (ssc_irq_n_i),
    .ssp_irq_n_i    (ssp_irq_n_i),
    .mb_irq_n_i     (mb_irq_n_i),
    .phi1_posedge_i (phi1_posedge_o),
    .phi1_negedge_i (phi1_negedge_o),
    .ssc_rd_i       (ssc_rd_i),
    .ssp_rd_i       (ssp_rd_i),
    .mb_rd_i        (mb_rd_i),
    .disk_rd_i      (disk_rd_i),
    .data_out_en_i  (data_out_en_o),
    .irq_n_i        (irq_n_o)
);

`default_nettype wire

// ==== verification/a2_card_tb.sv ====
// Table-driven testbench for the Apple II card glue top level
`timescale 1ns/1ps
`default_nettype none

`include "a2_card_macros.svh"

module a2_card_tb;
    import a2_bus_pkg::*;
    import a2_av_pkg::*;

    localparam int ROWS = 32;

    // One stimulus row with the outputs it should produce
    typedef struct packed {
        logic [3:0]               rd;
        logic [2:0]               irq_n;
        a2_data_t                 ssc_data;
        a2_data_t                 ssp_data;
        a2_data_t                 mb_data;
        a2_data_t                 disk_data;
        a2_data_t                 bus_data;
        sample_t                  ssp_audio;
        logic [`A2_MB_AUDIO_W-1:0] mb_l;
        logic [`A2_MB_AUDIO_W-1:0] mb_r;
        logic                     speaker;
        rgb_t                     rgb;
        logic [`A2_COORD_W-1:0]   screen_y;
        logic                     sleep;
        logic [`A2_DIP_W-1:0]     dip_n;
        logic                     button_n;
        logic                     soc_led;
        logic                     vdp_unlocked;
        logic [`A2_LED_W-2:0]     gmode;
        a2_data_t                 exp_data;
        logic                     exp_en;
        logic                     exp_irq_n;
        sample_t                  exp_audio_l;
        sample_t                  exp_audio_r;
        rgb_t                     exp_rgb;
        logic                     exp_oe;
        logic                     exp_scan;
        logic                     exp_spk;
        logic [`A2_LED_W-1:0]     exp_led;
    } row_t;

    logic clk_logic_w;
    logic rst_i;
    logic a2_phi1_i;
    logic a2_7m_i;
    logic ssc_rd_i;
    a2_data_t ssc_data_i;
    logic ssp_rd_i;
    a2_data_t ssp_data_i;
    logic mb_rd_i;
    a2_data_t mb_data_i;
    logic disk_rd_i;
    a2_data_t disk_data_i;
    logic ssc_irq_n_i;
    logic ssp_irq_n_i;
    logic mb_irq_n_i;
    a2_data_t bus_data_i;
    sample_t ssp_audio_i;
    logic [`A2_MB_AUDIO_W-1:0] mb_audio_l_i;
    logic [`A2_MB_AUDIO_W-1:0] mb_audio_r_i;
    logic speaker_i;
    rgb_t rgb_i;
    logic [`A2_COORD_W-1:0] screen_y_i;
    logic sleep_i;
    logic [`A2_DIP_W-1:0] dip_n_i;
    logic button_n_i;
    logic soc_led_i;
    logic vdp_unlocked_i;
    logic [`A2_LED_W-2:0] vdp_gmode_i;

    logic phi0_o;
    logic phi1_o;
    logic phi1_posedge_o;
    logic phi1_negedge_o;
    logic clk_2m_posedge_o;
    logic clk_7m_o;
    logic clk_7m_posedge_o;
    logic clk_7m_negedge_o;
    logic clk_14m_posedge_o;
    logic data_out_en_o;
    a2_data_t data_out_o;
    logic irq_n_o;
    sample_t audio_l_o;
    sample_t audio_r_o;
    rgb_t rgb_o;
    logic tmds_oe_o;
    logic scanlines_en_o;
    logic speaker_en_o;
    logic [`A2_LED_W-1:0] led_o;

    row_t rows [ROWS];
    int checks = 0;
    int errors = 0;
    int clk_errors = 0;
    int cnt_2m = 0;
    int cnt_14m = 0;
    int cnt_phi1_rise = 0;
    int cnt_phi1_fall = 0;
    int cnt_7m_rise = 0;
    int cnt_7m_fall = 0;

    a2_card_top dut0 (.*);

    initial begin
        clk_logic_w = 1'b0;
        forever #50 clk_logic_w = ~clk_logic_w;
    end

    // Pulse counters and phase check, sampled away from the active edge
    always @(negedge clk_logic_w) begin
        if (!rst_i) begin
            if (clk_2m_posedge_o) begin
                cnt_2m <= cnt_2m + 1;
            end
            if (clk_14m_posedge_o) begin
                cnt_14m <= cnt_14m + 1;
            end
            if (phi1_posedge_o) begin
                cnt_phi1_rise <= cnt_phi1_rise + 1;
            end
            if (phi1_negedge_o) begin
                cnt_phi1_fall <= cnt_phi1_fall + 1;
            end
            if (clk_7m_posedge_o) begin
                cnt_7m_rise <= cnt_7m_rise + 1;
            end
            if (clk_7m_negedge_o) begin
                cnt_7m_fall <= cnt_7m_fall + 1;
            end
            assert (phi0_o === ~phi1_o) else begin
                clk_errors <= clk_errors + 1;
                $display("Fail: time %0t, phi0_o is %b, expected %b", $time, phi0_o, ~phi1_o);
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Fail: time %0t, %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_reset_values();
        check_value("data_out_en_o", 32'(data_out_en_o), 32'(1'b0));
        check_value("irq_n_o", 32'(irq_n_o), 32'(1'b1));
        check_value("led_o", 32'(led_o), 32'({`A2_LED_W{1'b1}}));
        check_value("audio_l_o", 32'(audio_l_o), 32'(0));
        check_value("audio_r_o", 32'(audio_r_o), 32'(0));
        check_value("rgb_o", 32'(rgb_o), 32'(0));
        check_value("tmds_oe_o", 32'(tmds_oe_o), 32'(1'b0));
    endtask

    // Reference model written from the behavior of each block
    function automatic row_t add_expected(input row_t r);
        row_t e;
        logic dim;
        e = r;
        e.exp_scan = ~r.dip_n[0] | 1'(`A2_SCANLINES_DEFAULT);
        e.exp_spk = ~r.dip_n[1] | 1'(`A2_SPEAKER_DEFAULT);
        e.exp_data = r.rd[3] ? r.ssc_data :
                     r.rd[2] ? r.ssp_data :
                     r.rd[1] ? r.mb_data :
                     r.rd[0] ? r.disk_data : r.bus_data;
        e.exp_en = |r.rd;
        e.exp_irq_n = &r.irq_n;
        e.exp_audio_l = r.ssp_audio + (sample_t'(r.mb_l) << `A2_MB_SHIFT)
                      + (sample_t'(r.speaker & e.exp_spk) << `A2_SPK_SHIFT);
        e.exp_audio_r = r.ssp_audio + (sample_t'(r.mb_r) << `A2_MB_SHIFT)
                      + (sample_t'(r.speaker & e.exp_spk) << `A2_SPK_SHIFT);
        dim = e.exp_scan & r.screen_y[0];
        e.exp_rgb = r.rgb;
        if (dim) begin
            e.exp_rgb.r = r.rgb.r >> 1;
            e.exp_rgb.g = r.rgb.g >> 1;
            e.exp_rgb.b = r.rgb.b >> 1;
        end
        // Output enable drops only when sleeping with the sleep feature on
        e.exp_oe = (r.sleep && `A2_HDMI_SLEEP_ENABLE == 1) ? 1'b0 : 1'b1;
        e.exp_led = r.button_n ? {~r.vdp_unlocked, ~r.gmode} : {4'b1111, ~r.soc_led};
        return e;
    endfunction

    task automatic fill_rows();
        row_t r;
        for (int i = 0; i < ROWS; i++) begin
            r = '0;
            // Low bits walk every read combination, bit 4 the button
            r.rd = 4'(i);
            r.button_n = i[4];
            r.irq_n = 3'($urandom);
            r.ssc_data = a2_data_t'($urandom);
            r.ssp_data = a2_data_t'($urandom);
            r.mb_data = a2_data_t'($urandom);
            r.disk_data = a2_data_t'($urandom);
            r.bus_data = a2_data_t'($urandom);
            r.ssp_audio = sample_t'($urandom);
            r.mb_l = `A2_MB_AUDIO_W'($urandom);
            r.mb_r = `A2_MB_AUDIO_W'($urandom);
            r.speaker = 1'($urandom);
            r.rgb = rgb_t'($urandom);
            r.screen_y = `A2_COORD_W'($urandom);
            r.sleep = 1'($urandom);
            r.dip_n = `A2_DIP_W'($urandom);
            r.soc_led = 1'($urandom);
            r.vdp_unlocked = 1'($urandom);
            r.gmode = 4'($urandom);
            rows[i] = add_expected(r);
        end
    endtask

    task automatic apply_row(input row_t r);
        @(posedge clk_logic_w);
        ssc_rd_i <= r.rd[3];
        ssp_rd_i <= r.rd[2];
        mb_rd_i <= r.rd[1];
        disk_rd_i <= r.rd[0];
        ssc_irq_n_i <= r.irq_n[2];
        ssp_irq_n_i <= r.irq_n[1];
        mb_irq_n_i <= r.irq_n[0];
        ssc_data_i <= r.ssc_data;
        ssp_data_i <= r.ssp_data;
        mb_data_i <= r.mb_data;
        disk_data_i <= r.disk_data;
        bus_data_i <= r.bus_data;
        ssp_audio_i <= r.ssp_audio;
        mb_audio_l_i <= r.mb_l;
        mb_audio_r_i <= r.mb_r;
        speaker_i <= r.speaker;
        rgb_i <= r.rgb;
        screen_y_i <= r.screen_y;
        sleep_i <= r.sleep;
        dip_n_i <= r.dip_n;
        button_n_i <= r.button_n;
        soc_led_i <= r.soc_led;
        vdp_unlocked_i <= r.vdp_unlocked;
        vdp_gmode_i <= r.gmode;
    endtask

    task automatic check_row(input row_t r);
        check_value("data_out_o", 32'(data_out_o), 32'(r.exp_data));
        check_value("data_out_en_o", 32'(data_out_en_o), 32'(r.exp_en));
        check_value("irq_n_o", 32'(irq_n_o), 32'(r.exp_irq_n));
        check_value("audio_l_o", 32'(audio_l_o), 32'(r.exp_audio_l));
        check_value("audio_r_o", 32'(audio_r_o), 32'(r.exp_audio_r));
        check_value("rgb_o", 32'(rgb_o), 32'(r.exp_rgb));
        check_value("tmds_oe_o", 32'(tmds_oe_o), 32'(r.exp_oe));
        check_value("scanlines_en_o", 32'(scanlines_en_o), 32'(r.exp_scan));
        check_value("speaker_en_o", 32'(speaker_en_o), 32'(r.exp_spk));
        check_value("led_o", 32'(led_o), 32'(r.exp_led));
    endtask

    // n phi1 toggles and twice as many 7M toggles, then count the pulses
    task automatic run_clock_toggles(input int n);
        int start_2m;
        int start_14m;
        int start_phi_rise;
        int start_phi_fall;
        int start_7m_rise;
        int start_7m_fall;
        int exp_phi_rise;
        int guard;
        start_2m = cnt_2m;
        start_14m = cnt_14m;
        start_phi_rise = cnt_phi1_rise;
        start_phi_fall = cnt_phi1_fall;
        start_7m_rise = cnt_7m_rise;
        start_7m_fall = cnt_7m_fall;
        // From a low level the first phi1 toggle is a rise
        exp_phi_rise = a2_phi1_i ? n / 2 : (n + 1) / 2;
        for (int i = 0; i < n; i++) begin
            @(posedge clk_logic_w);
            a2_phi1_i <= ~a2_phi1_i;
            a2_7m_i <= ~a2_7m_i;
            repeat (2) @(posedge clk_logic_w);
            a2_7m_i <= ~a2_7m_i;
            repeat (2) @(posedge clk_logic_w);
        end
        for (guard = 0; guard < 20; guard++) begin
            if (cnt_2m - start_2m >= n && cnt_14m - start_14m >= 2 * n) begin
                break;
            end
            @(posedge clk_logic_w);
        end
        if (cnt_2m - start_2m < n || cnt_14m - start_14m < 2 * n) begin
            errors++;
            $display("Timeout: recovered bus clock pulses did not all arrive");
        end
        // Idle cycles expose any extra pulse
        repeat (4) @(posedge clk_logic_w);
        check_value("clk_2m_posedge_o count", 32'(cnt_2m - start_2m), 32'(n));
        check_value("clk_14m_posedge_o count", 32'(cnt_14m - start_14m), 32'(2 * n));
        check_value("phi1_posedge_o count", 32'(cnt_phi1_rise - start_phi_rise),
                    32'(exp_phi_rise));
        check_value("phi1_negedge_o count", 32'(cnt_phi1_fall - start_phi_fall),
                    32'(n - exp_phi_rise));
        check_value("clk_7m_posedge_o count", 32'(cnt_7m_rise - start_7m_rise), 32'(n));
        check_value("clk_7m_negedge_o count", 32'(cnt_7m_fall - start_7m_fall), 32'(n));
        @(negedge clk_logic_w);
        check_value("phi1_o", 32'(phi1_o), 32'(a2_phi1_i));
        check_value("clk_7m_o", 32'(clk_7m_o), 32'(a2_7m_i));
    endtask

    initial begin
        void'($urandom(1905));
        rst_i = 1'b1;
        a2_phi1_i = 1'b0;
        a2_7m_i = 1'b0;
        ssc_rd_i = 1'b0;
        ssp_rd_i = 1'b0;
        mb_rd_i = 1'b0;
        disk_rd_i = 1'b0;
        ssc_data_i = '0;
        ssp_data_i = '0;
        mb_data_i = '0;
        disk_data_i = '0;
        ssc_irq_n_i = 1'b1;
        ssp_irq_n_i = 1'b1;
        mb_irq_n_i = 1'b1;
        bus_data_i = '0;
        ssp_audio_i = '0;
        mb_audio_l_i = '0;
        mb_audio_r_i = '0;
        speaker_i = 1'b0;
        rgb_i = '0;
        screen_y_i = '0;
        sleep_i = 1'b1;
        dip_n_i = '1;
        button_n_i = 1'b1;
        soc_led_i = 1'b0;
        vdp_unlocked_i = 1'b0;
        vdp_gmode_i = '0;

        // Ten clock edges in reset
        repeat (9) @(posedge clk_logic_w);
        @(negedge clk_logic_w);
        check_reset_values();
        @(posedge clk_logic_w);
        rst_i <= 1'b0;
        @(posedge clk_logic_w);
        @(negedge clk_logic_w);
        check_reset_values();

        fill_rows();
        for (int i = 0; i < ROWS; i++) begin
            apply_row(rows[i]);
            @(posedge clk_logic_w);
            @(negedge clk_logic_w);
            check_row(rows[i]);
        end

        run_clock_toggles(6);

        $display("Summary: %0d checks, %0d value errors, %0d clock phase errors",
                 checks, errors, clk_errors);
        if (errors == 0 && clk_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/a2_audio_mixer.sv ====
// Audio mixer summing sprite, Mockingboard and speaker into one 16-bit sample
`timescale 1ns/1ps
`default_nettype none

`include "a2_card_macros.svh"

module a2_audio_mixer (
    input  wire                        clk_logic_w,
    input  wire                        rst_i,
    input  a2_av_pkg::sample_t         ssp_audio_i,
    input  wire [`A2_MB_AUDIO_W-1:0]   mb_audio_i,
    input  wire                        speaker_i,
    input  wire                        speaker_en_i,
    output a2_av_pkg::sample_t         audio_o
);
    import a2_av_pkg::*;

    sample_t mb_term_w;
    sample_t spk_term_w;

    // Mockingboard lands in the upper bits of the sample
    assign mb_term_w  = sample_t'(mb_audio_i) << `A2_MB_SHIFT;

    // Speaker is a single loud bit
    assign spk_term_w = sample_t'(speaker_i & speaker_en_i) << `A2_SPK_SHIFT;

    // Sum wraps at the sample width
    always_ff @(posedge clk_logic_w) begin
        if (rst_i) begin
            audio_o <= '0;
        end else begin
            audio_o <= ssp_audio_i + mb_term_w + spk_term_w;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/a2_av_pkg.sv ====
// Audio and video types for the mixer, video post stage and front panel
`default_nettype none

`include "a2_card_macros.svh"

package a2_av_pkg;

    // Unsigned audio sample fed to the output stage
    typedef logic [`A2_SAMPLE_W-1:0] sample_t;

    // One colour channel
    typedef logic [`A2_COLOR_W-1:0] color_t;

    // Packed pixel, red in the top byte
    typedef struct packed {
        color_t r;
        color_t g;
        color_t b;
    } rgb_t;

    // What the LEDs show
    typedef enum logic {
        LED_SOC = 1'b0,
        LED_VDP = 1'b1
    } led_mode_e;

endpackage

`default_nettype wire

// ==== verilog/a2_bus_pkg.sv ====
// Apple II bus types shared by the card interface and the response arbiter
`default_nettype none

`include "a2_card_macros.svh"

package a2_bus_pkg;

    // One byte on the Apple data bus
    typedef logic [`A2_DATA_W-1:0] a2_data_t;

    // Card that owns the data bus in the current cycle
    typedef enum logic [2:0] {
        CARD_NONE = 3'd0,
        CARD_SSC  = 3'd1,
        CARD_SSP  = 3'd2,
        CARD_MB   = 3'd3,
        CARD_DISK = 3'd4
    } card_sel_e;

endpackage

`default_nettype wire

// ==== verilog/a2_card_arbiter.sv ====
// Card response arbiter merging read data by fixed priority and combining interrupts
`timescale 1ns/1ps
`default_nettype none

module a2_card_arbiter (
    input  wire                  clk_logic_w,
    input  wire                  rst_i,
    card_resp_if.arb             cards,
    input  a2_bus_pkg::a2_data_t bus_data_i,
    output logic                 data_out_en_o,
    output a2_bus_pkg::a2_data_t data_out_o,
    output logic                 irq_n_o
);
    import a2_bus_pkg::*;

    card_sel_e sel_w;
    a2_data_t  data_w;

    // SSC wins over SSP, then Mockingboard, then Disk II
    always_comb begin
        if (cards.ssc_rd) begin
            sel_w = CARD_SSC;
        end else if (cards.ssp_rd) begin
            sel_w = CARD_SSP;
        end else if (cards.mb_rd) begin
            sel_w = CARD_MB;
        end else if (cards.disk_rd) begin
            sel_w = CARD_DISK;
        end else begin
            sel_w = CARD_NONE;
        end
    end

    always_comb begin
        case (sel_w)
            CARD_SSC:  data_w = cards.ssc_data;
            CARD_SSP:  data_w = cards.ssp_data;
            CARD_MB:   data_w = cards.mb_data;
            CARD_DISK: data_w = cards.disk_data;
            // Nobody answers so the bus byte passes through
            default:   data_w = bus_data_i;
        endcase
    end

    always_ff @(posedge clk_logic_w) begin
        if (rst_i) begin
            data_out_en_o <= 1'b0;
            irq_n_o       <= 1'b1;
        end else begin
            data_out_en_o <= cards.ssc_rd | cards.ssp_rd | cards.mb_rd | cards.disk_rd;
            irq_n_o       <= cards.mb_irq_n & cards.ssp_irq_n & cards.ssc_irq_n;
        end
    end

    always_ff @(posedge clk_logic_w) begin
        data_out_o <= data_w;
    end

endmodule

`default_nettype wire

// ==== verilog/a2_card_macros.svh ====
// Apple II card glue logic widths, shift amounts and enable defaults
`ifndef A2_CARD_MACROS_SVH
`define A2_CARD_MACROS_SVH

// Bus and audio widths
`define A2_DATA_W 8
`define A2_SAMPLE_W 16
`define A2_MB_AUDIO_W 10
`define A2_MB_SHIFT 5
`define A2_SPK_SHIFT 13

// Video and clock recovery
`define A2_COLOR_W 8
`define A2_COORD_W 10
`define A2_SYNC_STAGES 2

// Front panel and feature defaults
`define A2_DIP_W 4
`define A2_LED_W 5
`define A2_SCANLINES_DEFAULT 0
`define A2_SPEAKER_DEFAULT 0
`define A2_HDMI_SLEEP_ENABLE 1

`endif

// ==== verilog/a2_card_top.sv ====
// Apple II card glue top level tying clock recovery, arbiter, audio, video and panel
`timescale 1ns/1ps
`default_nettype none

`include "a2_card_macros.svh"

module a2_card_top (
    input  wire                     clk_logic_w,
    input  wire                     rst_i,
    // Apple bus clocks
    input  wire                     a2_phi1_i,
    input  wire                     a2_7m_i,
    // Card responses
    input  wire                     ssc_rd_i,
    input  a2_bus_pkg::a2_data_t    ssc_data_i,
    input  wire                     ssp_rd_i,
    input  a2_bus_pkg::a2_data_t    ssp_data_i,
    input  wire                     mb_rd_i,
    input  a2_bus_pkg::a2_data_t    mb_data_i,
    input  wire                     disk_rd_i,
    input  a2_bus_pkg::a2_data_t    disk_data_i,
    input  wire                     ssc_irq_n_i,
    input  wire                     ssp_irq_n_i,
    input  wire                     mb_irq_n_i,
    input  a2_bus_pkg::a2_data_t    bus_data_i,
    // Audio sources
    input  a2_av_pkg::sample_t      ssp_audio_i,
    input  wire [`A2_MB_AUDIO_W-1:0] mb_audio_l_i,
    input  wire [`A2_MB_AUDIO_W-1:0] mb_audio_r_i,
    input  wire                     speaker_i,
    // Video
    input  a2_av_pkg::rgb_t         rgb_i,
    input  wire [`A2_COORD_W-1:0]   screen_y_i,
    input  wire                     sleep_i,
    // Front panel
    input  wire [`A2_DIP_W-1:0]     dip_n_i,
    input  wire                     button_n_i,
    input  wire                     soc_led_i,
    input  wire                     vdp_unlocked_i,
    input  wire [`A2_LED_W-2:0]     vdp_gmode_i,
    // Recovered bus clocks
    output logic                    phi0_o,
    output logic                    phi1_o,
    output logic                    phi1_posedge_o,
    output logic                    phi1_negedge_o,
    output logic                    clk_2m_posedge_o,
    output logic                    clk_7m_o,
    output logic                    clk_7m_posedge_o,
    output logic                    clk_7m_negedge_o,
    output logic                    clk_14m_posedge_o,
    // Bus response
    output logic                    data_out_en_o,
    output a2_bus_pkg::a2_data_t    data_out_o,
    output logic                    irq_n_o,
    // Audio, video and panel
    output a2_av_pkg::sample_t      audio_l_o,
    output a2_av_pkg::sample_t      audio_r_o,
    output a2_av_pkg::rgb_t         rgb_o,
    output logic                    tmds_oe_o,
    output logic                    scanlines_en_o,
    output logic                    speaker_en_o,
    output logic [`A2_LED_W-1:0]    led_o
);

    card_resp_if cards_if ();

    assign cards_if.ssc_rd    = ssc_rd_i;
    assign cards_if.ssc_data  = ssc_data_i;
    assign cards_if.ssp_rd    = ssp_rd_i;
    assign cards_if.ssp_data  = ssp_data_i;
    assign cards_if.mb_rd     = mb_rd_i;
    assign cards_if.mb_data   = mb_data_i;
    assign cards_if.disk_rd   = disk_rd_i;
    assign cards_if.disk_data = disk_data_i;
    assign cards_if.mb_irq_n  = mb_irq_n_i;
    assign cards_if.ssp_irq_n = ssp_irq_n_i;
    assign cards_if.ssc_irq_n = ssc_irq_n_i;

    a2_clock_recovery clk_rec (
        .clk_logic_w       (clk_logic_w),
        .rst_i             (rst_i),
        .a2_phi1_i         (a2_phi1_i),
        .a2_7m_i           (a2_7m_i),
        .phi0_o            (phi0_o),
        .phi1_o            (phi1_o),
        .phi1_posedge_o    (phi1_posedge_o),
        .phi1_negedge_o    (phi1_negedge_o),
        .clk_2m_posedge_o  (clk_2m_posedge_o),
        .clk_7m_o          (clk_7m_o),
        .clk_7m_posedge_o  (clk_7m_posedge_o),
        .clk_7m_negedge_o  (clk_7m_negedge_o),
        .clk_14m_posedge_o (clk_14m_posedge_o)
    );

    a2_card_arbiter arbiter (
        .clk_logic_w   (clk_logic_w),
        .rst_i         (rst_i),
        .cards         (cards_if.arb),
        .bus_data_i    (bus_data_i),
        .data_out_en_o (data_out_en_o),
        .data_out_o    (data_out_o),
        .irq_n_o       (irq_n_o)
    );

    // Sprite audio is mono and feeds both sides
    a2_audio_mixer mix_l (
        .clk_logic_w  (clk_logic_w),
        .rst_i        (rst_i),
        .ssp_audio_i  (ssp_audio_i),
        .mb_audio_i   (mb_audio_l_i),
        .speaker_i    (speaker_i),
        .speaker_en_i (speaker_en_o),
        .audio_o      (audio_l_o)
    );

    a2_audio_mixer mix_r (
        .clk_logic_w  (clk_logic_w),
        .rst_i        (rst_i),
        .ssp_audio_i  (ssp_audio_i),
        .mb_audio_i   (mb_audio_r_i),
        .speaker_i    (speaker_i),
        .speaker_en_i (speaker_en_o),
        .audio_o      (audio_r_o)
    );

    a2_video_post video_post (
        .clk_logic_w    (clk_logic_w),
        .rst_i          (rst_i),
        .rgb_i          (rgb_i),
        .screen_y_i     (screen_y_i),
        .scanlines_en_i (scanlines_en_o),
        .sleep_i        (sleep_i),
        .rgb_o          (rgb_o),
        .tmds_oe_o      (tmds_oe_o)
    );

    a2_front_panel front_panel (
        .clk_logic_w    (clk_logic_w),
        .rst_i          (rst_i),
        .dip_n_i        (dip_n_i),
        .button_n_i     (button_n_i),
        .soc_led_i      (soc_led_i),
        .vdp_unlocked_i (vdp_unlocked_i),
        .vdp_gmode_i    (vdp_gmode_i),
        .scanlines_en_o (scanlines_en_o),
        .speaker_en_o   (speaker_en_o),
        .led_o          (led_o)
    );

endmodule

`default_nettype wire

// ==== verilog/a2_clock_recovery.sv ====
// Bus clock recovery bringing phi1 and 7M into the logic clock with edge pulses
`timescale 1ns/1ps
`default_nettype none

`include "a2_card_macros.svh"

module a2_clock_recovery (
    input  wire  clk_logic_w,
    input  wire  rst_i,
    input  wire  a2_phi1_i,
    input  wire  a2_7m_i,
    output logic phi0_o,
    output logic phi1_o,
    output logic phi1_posedge_o,
    output logic phi1_negedge_o,
    output logic clk_2m_posedge_o,
    output logic clk_7m_o,
    output logic clk_7m_posedge_o,
    output logic clk_7m_negedge_o,
    output logic clk_14m_posedge_o
);

    // Bit 0 carries phi1, bit 1 carries 7M
    logic [1:0] raw_w;
    logic [`A2_SYNC_STAGES-1:0][1:0] sync_q;
    logic [1:0] sync_w;
    logic [1:0] dly_q;
    logic [1:0] rise_w;
    logic [1:0] fall_w;

    assign raw_w  = {a2_7m_i, a2_phi1_i};
    assign sync_w = sync_q[`A2_SYNC_STAGES-1];

    always_ff @(posedge clk_logic_w) begin
        if (rst_i) begin
            sync_q <= '0;
            dly_q  <= '0;
        end else begin
            sync_q <= {sync_q[`A2_SYNC_STAGES-2:0], raw_w};
            dly_q  <= sync_w;
        end
    end

    // One pulse per input transition
    assign rise_w = sync_w & ~dly_q;
    assign fall_w = ~sync_w & dly_q;

    assign phi1_o            = sync_w[0];
    assign phi0_o            = ~sync_w[0];
    assign phi1_posedge_o    = rise_w[0];
    assign phi1_negedge_o    = fall_w[0];
    assign clk_2m_posedge_o  = rise_w[0] | fall_w[0];

    assign clk_7m_o          = sync_w[1];
    assign clk_7m_posedge_o  = rise_w[1];
    assign clk_7m_negedge_o  = fall_w[1];
    // Both 7M edges give the 14M rate
    assign clk_14m_posedge_o = rise_w[1] | fall_w[1];

endmodule

`default_nettype wire

// ==== verilog/a2_front_panel.sv ====
// Front panel decoding the DIP switches and driving the LEDs by button mode
`timescale 1ns/1ps
`default_nettype none

`include "a2_card_macros.svh"

module a2_front_panel (
    input  wire                     clk_logic_w,
    input  wire                     rst_i,
    input  wire [`A2_DIP_W-1:0]     dip_n_i,
    input  wire                     button_n_i,
    input  wire                     soc_led_i,
    input  wire                     vdp_unlocked_i,
    input  wire [`A2_LED_W-2:0]     vdp_gmode_i,
    output logic                    scanlines_en_o,
    output logic                    speaker_en_o,
    output logic [`A2_LED_W-1:0]    led_o
);
    import a2_av_pkg::*;

    led_mode_e led_mode_w;

    // Switches are active low
    assign scanlines_en_o = ~dip_n_i[0] | 1'(`A2_SCANLINES_DEFAULT);
    assign speaker_en_o   = ~dip_n_i[1] | 1'(`A2_SPEAKER_DEFAULT);

    assign led_mode_w = button_n_i ? LED_VDP : LED_SOC;

    // LEDs are active low, so all ones is dark
    always_ff @(posedge clk_logic_w) begin
        if (rst_i) begin
            led_o <= '1;
        end else if (led_mode_w == LED_SOC) begin
            led_o <= {{(`A2_LED_W-1){1'b1}}, ~soc_led_i};
        end else begin
            led_o <= {~vdp_unlocked_i, ~vdp_gmode_i};
        end
    end

endmodule

`default_nettype wire

// ==== verilog/a2_video_post.sv ====
// Video post stage with scanline dimming and TMDS output enable
`timescale 1ns/1ps
`default_nettype none

`include "a2_card_macros.svh"

module a2_video_post (
    input  wire                     clk_logic_w,
    input  wire                     rst_i,
    input  a2_av_pkg::rgb_t         rgb_i,
    input  wire [`A2_COORD_W-1:0]   screen_y_i,
    input  wire                     scanlines_en_i,
    input  wire                     sleep_i,
    output a2_av_pkg::rgb_t         rgb_o,
    output logic                    tmds_oe_o
);
    import a2_av_pkg::*;

    logic dim_w;
    rgb_t rgb_w;

    // Odd lines get half brightness
    assign dim_w = scanlines_en_i & screen_y_i[0];

    always_comb begin
        rgb_w = rgb_i;
        if (dim_w) begin
            rgb_w.r = rgb_i.r >> 1;
            rgb_w.g = rgb_i.g >> 1;
            rgb_w.b = rgb_i.b >> 1;
        end
    end

    always_ff @(posedge clk_logic_w) begin
        if (rst_i) begin
            rgb_o     <= '0;
            tmds_oe_o <= 1'b0;
        end else begin
            rgb_o     <= rgb_w;
            // Output goes dark while the bus sleeps
            tmds_oe_o <= ~(sleep_i & 1'(`A2_HDMI_SLEEP_ENABLE));
        end
    end

endmodule

`default_nettype wire

// ==== verilog/card_resp_if.sv ====
// Card response bundle with read strobes, read data and interrupt lines
`timescale 1ns/1ps
`default_nettype none

interface card_resp_if;
    import a2_bus_pkg::*;

    // Read enables and data per card
    logic     ssc_rd;
    a2_data_t ssc_data;
    logic     ssp_rd;
    a2_data_t ssp_data;
    logic     mb_rd;
    a2_data_t mb_data;
    logic     disk_rd;
    a2_data_t disk_data;

    // Active-low interrupts, Disk II has none
    logic     mb_irq_n;
    logic     ssp_irq_n;
    logic     ssc_irq_n;

    modport src (
        output ssc_rd, ssc_data, ssp_rd, ssp_data, mb_rd, mb_data, disk_rd, disk_data,
        output mb_irq_n, ssp_irq_n, ssc_irq_n
    );

    modport arb (
        input ssc_rd, ssc_data, ssp_rd, ssp_data, mb_rd, mb_data, disk_rd, disk_data,
        input mb_irq_n, ssp_irq_n, ssc_irq_n
    );

endinterface

`default_nettype wire
